//--- hw/cart_pkg.sv
//////////////////////////////////////////////////
// cartridge load front end shared definitions
// widths, header addresses, quirk bit positions
// and lightgun sensor delays
//////////////////////////////////////////////////
`default_nettype none

package cart_pkg;

	//////////////////////////////////////////////////
	// stream widths
	//////////////////////////////////////////////////

	// loader byte address and data word
	localparam int load_addr_w = 25;
	localparam int word_w = 16;
	// word address toward rom memory, byte address without bit 0
	localparam int ram_addr_w = 24;

	typedef logic [load_addr_w-1:0] load_addr_t;
	typedef logic [word_w-1:0] word_t;

	//////////////////////////////////////////////////
	// header layout
	//////////////////////////////////////////////////

	// region letters live in these two words
	localparam load_addr_t hdr_region_lo = 25'h1F0;
	localparam load_addr_t hdr_region_hi = 25'h1F2;
	// first word past the header
	localparam load_addr_t hdr_end = 25'h200;

	// product id spans five words from here
	localparam load_addr_t id_addr_first = 25'h182;
	// id is complete by the time this word is written
	localparam load_addr_t id_addr_decode = 25'h18C;

	// eight ascii characters
	typedef logic [63:0] product_id_t;

	// compatibility quirk flags, one bit each
	typedef logic [7:0] quirk_t;
	localparam int quirk_sram = 0;
	localparam int quirk_eeprom = 1;
	localparam int quirk_noram = 2;
	localparam int quirk_fifo = 3;
	localparam int quirk_pier = 4;
	localparam int quirk_svp = 5;
	localparam int quirk_fmbusy = 6;
	localparam int quirk_schan = 7;

	//////////////////////////////////////////////////
	// lightgun sensor delays
	//////////////////////////////////////////////////
	localparam int gun_delay_w = 8;
	localparam logic [gun_delay_w-1:0] gun_delay_default = 8'd44;
	localparam logic [gun_delay_w-1:0] gun_delay_mk1533 = 8'd100;
	localparam logic [gun_delay_w-1:0] gun_delay_t95096 = 8'd52;
	localparam logic [gun_delay_w-1:0] gun_delay_t95136 = 8'd30;
	localparam logic [gun_delay_w-1:0] gun_delay_mk1658 = 8'd120;
	localparam logic [gun_delay_w-1:0] gun_delay_t081156 = 8'd126;

	// cheat code is flags, address, compare, replace, 32 bits each
	localparam int code_w = 128;
	typedef logic [code_w-1:0] code_t;

endpackage

`default_nettype wire

//--- hw/rom_write_sync.sv
//////////////////////////////////////////////////
// rom write synchronizer
// hands each cartridge word to rom memory over a
// toggle req/ack pair and stalls the loader
//////////////////////////////////////////////////
`timescale 1ns/100ps
`default_nettype none

module rom_write_sync (
	input wire clk_sys,
	input wire rst,
	input wire cart_active,
	input wire load_wr,
	input wire cart_pkg::load_addr_t load_addr,
	input wire cart_pkg::word_t load_wdata,
	input wire ram_ack,
	output logic load_wait,
	output logic ram_req,
	output logic [cart_pkg::ram_addr_w-1:0] ram_addr,
	output cart_pkg::word_t ram_wdata
);

	import cart_pkg::*;

	logic cart_wr;

	// only rom image words go to memory, cheat data never does
	assign cart_wr = cart_active & load_wr;

	//////////////////////////////////////////////////
	// request toggle and loader wait
	//////////////////////////////////////////////////
	always_ff @(posedge clk_sys) begin
		if (rst) begin
			load_wait <= 1'b0;
			ram_req <= 1'b0;
		end else if (cart_wr) begin
			// new write, flip req and hold the loader off
			load_wait <= 1'b1;
			ram_req <= ~ram_req;
		end else if (load_wait && (ram_ack == ram_req)) begin
			// memory caught up with the toggle
			load_wait <= 1'b0;
		end
	end

	//////////////////////////////////////////////////
	// address and data hold
	//////////////////////////////////////////////////
	// stays put until the next strobe, so stable through the ack
	always_ff @(posedge clk_sys) begin
		if (cart_wr) begin
			// word address, drop the byte select bit
			ram_addr <= load_addr[load_addr_w-1:1];
			// image is big endian, memory wants the bytes swapped
			ram_wdata <= {load_wdata[word_w/2-1:0], load_wdata[word_w-1:word_w/2]};
		end
	end

endmodule

`default_nettype wire

//--- hw/header_region.sv
//////////////////////////////////////////////////
// header region scan
// picks the J, U and E region letters out of the
// cartridge header and flags header completion
//////////////////////////////////////////////////
`timescale 1ns/100ps
`default_nettype none

module header_region (
	input wire clk_sys,
	input wire rst,
	input wire cart_active,
	input wire load_wr,
	input wire cart_pkg::load_addr_t load_addr,
	input wire cart_pkg::word_t load_wdata,
	output logic region_j,
	output logic region_u,
	output logic region_e,
	output logic header_ready
);

	import cart_pkg::*;

	logic old_active;
	logic stream_start;
	logic stream_end;
	logic cart_wr;
	logic [2:0] hit_lo;
	logic [2:0] hit_hi;
	logic [2:0] hit;

	// one header byte to {j, u, e}
	function automatic logic [2:0] region_of(input logic [7:0] b);
		if (b == "J") begin
			return 3'b100;
		end else if (b == "U") begin
			return 3'b010;
		end else if (b >= "0" && b <= "Z") begin
			// any other letter or digit counts as europe
			return 3'b001;
		end
		return 3'b000;
	endfunction

	// stream edges from the delayed level
	assign stream_start = cart_active & ~old_active;
	assign stream_end = ~cart_active & old_active;
	assign cart_wr = cart_active & load_wr;

	//////////////////////////////////////////////////
	// byte classification
	//////////////////////////////////////////////////
	always_comb begin
		hit_lo = 3'b000;
		hit_hi = 3'b000;
		// low byte counts in both region words
		if (load_addr == hdr_region_lo || load_addr == hdr_region_hi) begin
			hit_lo = region_of(load_wdata[7:0]);
		end
		// high byte only in the first one
		if (load_addr == hdr_region_lo) begin
			hit_hi = region_of(load_wdata[15:8]);
		end
	end

	assign hit = hit_lo | hit_hi;

	//////////////////////////////////////////////////
	// flag registers
	//////////////////////////////////////////////////
	always_ff @(posedge clk_sys) begin
		if (rst) begin
			old_active <= 1'b0;
			{region_j, region_u, region_e} <= 3'b000;
			header_ready <= 1'b0;
		end else begin
			old_active <= cart_active;
			// flags are sticky within a stream, cleared when a new one starts
			{region_j, region_u, region_e} <=
				(stream_start ? 3'b000 : {region_j, region_u, region_e}) |
				(cart_wr ? hit : 3'b000);
			if (cart_wr && load_addr == hdr_end) begin
				header_ready <= 1'b1;
			end else if (stream_end) begin
				header_ready <= 1'b0;
			end
		end
	end

endmodule

`default_nettype wire

//--- hw/cart_quirk_table.sv
//////////////////////////////////////////////////
// cartridge quirk table
// collects the product id from the header and
// looks up quirk flags and lightgun settings
//////////////////////////////////////////////////
`timescale 1ns/100ps
`default_nettype none

module cart_quirk_table (
	input wire clk_sys,
	input wire rst,
	input wire cart_active,
	input wire load_wr,
	input wire cart_pkg::load_addr_t load_addr,
	input wire cart_pkg::word_t load_wdata,
	output cart_pkg::quirk_t quirks,
	output logic gun_type,
	output logic [cart_pkg::gun_delay_w-1:0] gun_delay
);

	import cart_pkg::*;

	product_id_t product_id;
	logic old_active;
	logic stream_start;
	logic cart_wr;
	logic decode;
	quirk_t id_quirk;
	logic id_gun_type;
	logic [gun_delay_w-1:0] id_gun_delay;

	assign cart_wr = cart_active & load_wr;
	assign stream_start = cart_active & ~old_active;
	assign decode = cart_wr && (load_addr == id_addr_decode);

	//////////////////////////////////////////////////
	// product id capture
	//////////////////////////////////////////////////
	// id starts on the odd byte 0x183, so words are realigned
	always_ff @(posedge clk_sys) begin
		if (cart_wr) begin
			if (load_addr == id_addr_first)
				product_id[63:56] <= load_wdata[15:8];
			if (load_addr == id_addr_first + 25'd2)
				product_id[55:40] <= {load_wdata[7:0], load_wdata[15:8]};
			if (load_addr == id_addr_first + 25'd4)
				product_id[39:24] <= {load_wdata[7:0], load_wdata[15:8]};
			if (load_addr == id_addr_first + 25'd6)
				product_id[23:8] <= {load_wdata[7:0], load_wdata[15:8]};
			if (load_addr == id_addr_first + 25'd8)
				product_id[7:0] <= load_wdata[7:0];
		end
	end

	//////////////////////////////////////////////////
	// id lookup
	//////////////////////////////////////////////////
	always_comb begin
		id_quirk = '0;
		case (product_id)
			"T-081276", "T-81406 ", "T-081586", "T-81576 ", "T-81476 ":
				id_quirk[quirk_sram] = 1'b1;
			"MK-1215 ", "G-4060  ", "00001211", "MK-1228 ", "G-5538  ",
			"00004076", "T-12046 ", "T-12053 ", "G-4524  ":
				id_quirk[quirk_eeprom] = 1'b1;
			// fake ram check in this one
			"T-113016": id_quirk[quirk_noram] = 1'b1;
			"T-89016 ": id_quirk[quirk_fifo] = 1'b1;
			"T-574023", "T-574013": id_quirk[quirk_pier] = 1'b1;
			// svp coprocessor titles
			"MK-1229 ", "G-7001  ": id_quirk[quirk_svp] = 1'b1;
			"T-35036 ", "T-25073 ", "MK-1137-": id_quirk[quirk_fmbusy] = 1'b1;
			"T-68???-": id_quirk[quirk_schan] = 1'b1;
			default: id_quirk = '0;
		endcase
	end

	// gun type 1 is the alternate reload style
	always_comb begin
		id_gun_type = 1'b0;
		case (product_id)
			"MK-1533 ": id_gun_delay = gun_delay_mk1533;
			"T-95096-": begin
				id_gun_type = 1'b1;
				id_gun_delay = gun_delay_t95096;
			end
			"T-95136-": begin
				id_gun_type = 1'b1;
				id_gun_delay = gun_delay_t95136;
			end
			"MK-1658 ": id_gun_delay = gun_delay_mk1658;
			"T-081156": id_gun_delay = gun_delay_t081156;
			default: id_gun_delay = gun_delay_default;
		endcase
	end

	//////////////////////////////////////////////////
	// result registers
	//////////////////////////////////////////////////
	always_ff @(posedge clk_sys) begin
		if (rst) begin
			old_active <= 1'b0;
			quirks <= '0;
			gun_type <= 1'b0;
			gun_delay <= gun_delay_default;
		end else begin
			old_active <= cart_active;
			// quirks start clean per cartridge, gun settings just follow the id
			quirks <= (stream_start ? quirk_t'('0) : quirks) | (decode ? id_quirk : quirk_t'('0));
			if (decode) begin
				gun_type <= id_gun_type;
				gun_delay <= id_gun_delay;
			end
		end
	end

endmodule

`default_nettype wire

//--- hw/cheat_code_loader.sv
//////////////////////////////////////////////////
// cheat code loader
// builds 128-bit codes from the word stream,
// flags, address, compare and replace words
//////////////////////////////////////////////////
`timescale 1ns/100ps
`default_nettype none

module cheat_code_loader (
	input wire clk_sys,
	input wire rst,
	input wire code_active,
	input wire load_wr,
	input wire cart_pkg::load_addr_t load_addr,
	input wire cart_pkg::word_t load_wdata,
	output cart_pkg::code_t code,
	output logic code_valid,
	output logic code_reset
);

	import cart_pkg::*;

	logic code_wr;
	logic [3:0] offset;
	logic [6:0] slot_lsb;

	assign code_wr = code_active & load_wr;
	// byte offset inside one 16-byte code record
	assign offset = load_addr[3:0];

	// field order is flags at the top, replace at the bottom
	// offset bits 3:2 pick the field, bit 1 the upper half
	assign slot_lsb = {~offset[3], ~offset[2], offset[1], 4'b0000};

	//////////////////////////////////////////////////
	// code assembly
	//////////////////////////////////////////////////
	// words land as given, byte order is up to the code generator
	always_ff @(posedge clk_sys) begin
		if (code_wr && !offset[0]) begin
			code[slot_lsb +: word_w] <= load_wdata;
		end
	end

	//////////////////////////////////////////////////
	// strobes
	//////////////////////////////////////////////////
	always_ff @(posedge clk_sys) begin
		if (rst) begin
			code_valid <= 1'b0;
			code_reset <= 1'b0;
		end else begin
			// replace top word is the last of the record
			code_valid <= code_wr && (offset == 4'd14);
			// first word of the stream wipes the stored codes downstream
			code_reset <= code_wr && (load_addr == '0);
		end
	end

endmodule

`default_nettype wire

//--- hw/cart_load_top.sv
//////////////////////////////////////////////////
// cartridge load front end top level
// splits the loader stream into rom writes,
// header scan, quirk lookup and cheat codes
//////////////////////////////////////////////////
`timescale 1ns/100ps
`default_nettype none

module cart_load_top (
	input wire clk_sys,
	input wire rst,
	// loader side
	input wire load_active,
	input wire load_is_code,
	input wire load_wr,
	input wire cart_pkg::load_addr_t load_addr,
	input wire cart_pkg::word_t load_wdata,
	output logic load_wait,
	// rom memory side
	output logic ram_req,
	input wire ram_ack,
	output logic [cart_pkg::ram_addr_w-1:0] ram_addr,
	output cart_pkg::word_t ram_wdata,
	// header results
	output logic region_j,
	output logic region_u,
	output logic region_e,
	output logic header_ready,
	output cart_pkg::quirk_t quirks,
	output logic gun_type,
	output logic [cart_pkg::gun_delay_w-1:0] gun_delay,
	// cheat codes
	output cart_pkg::code_t code,
	output logic code_valid,
	output logic code_reset
);

	logic cart_active;
	logic code_active;

	// one stream at a time, either rom image or cheat data
	assign cart_active = load_active & ~load_is_code;
	assign code_active = load_active & load_is_code;

	rom_write_sync rom_sync0 (
		.clk_sys, .rst, .cart_active, .load_wr, .load_addr, .load_wdata,
		.ram_ack, .load_wait, .ram_req, .ram_addr, .ram_wdata
	);

	header_region region0 (
		.clk_sys, .rst, .cart_active, .load_wr, .load_addr, .load_wdata,
		.region_j, .region_u, .region_e, .header_ready
	);

	cart_quirk_table quirk0 (
		.clk_sys, .rst, .cart_active, .load_wr, .load_addr, .load_wdata,
		.quirks, .gun_type, .gun_delay
	);

	cheat_code_loader cheat0 (
		.clk_sys, .rst, .code_active, .load_wr, .load_addr, .load_wdata,
		.code, .code_valid, .code_reset
	);

endmodule

`default_nettype wire

//--- bench/cart_load_vectors.svh
//////////////////////////////////////////////////
// cartridge load testbench vectors
// cart headers and cheat records with the region,
// quirk, gun and code results they should give
//////////////////////////////////////////////////
`ifndef CART_LOAD_VECTORS_SVH
`define CART_LOAD_VECTORS_SVH

// memory ack delay in cycles and slack on the cycle limit
localparam int ack_delay_max = 4;
localparam int timeout_margin = 100;

// region is {j, u, e}
typedef struct packed {
	logic [63:0] id;
	logic [15:0] reg_lo;
	logic [15:0] reg_hi;
	logic [2:0] region;
	logic [7:0] quirks;
	logic gun_type;
	logic [7:0] gun_delay;
} cart_vec_t;

localparam int n_cart = 15;
localparam cart_vec_t cart_vecs [n_cart] = '{
	'{"T-081276", "J ", "  ", 3'b100, 8'h01, 1'b0, 8'd44},
	'{"MK-1215 ", "  ", " U", 3'b010, 8'h02, 1'b0, 8'd44},
	'{"T-113016", "4 ", "  ", 3'b001, 8'h04, 1'b0, 8'd44},
	'{"T-89016 ", "JU", " E", 3'b111, 8'h08, 1'b0, 8'd44},
	'{"T-574023", "  ", "  ", 3'b000, 8'h10, 1'b0, 8'd44},
	// lower case sits above Z
	'{"MK-1229 ", "ab", "  ", 3'b000, 8'h20, 1'b0, 8'd44},
	'{"T-35036 ", "UE", "  ", 3'b011, 8'h40, 1'b0, 8'd44},
	// high byte of the second region word is ignored
	'{"T-68???-", "  ", "J?", 3'b001, 8'h80, 1'b0, 8'd44},
	'{"UNKNOWN1", "E ", "  ", 3'b001, 8'h00, 1'b0, 8'd44},
	'{"MK-1533 ", "U ", "  ", 3'b010, 8'h00, 1'b0, 8'd100},
	'{"T-95096-", "  ", " J", 3'b100, 8'h00, 1'b1, 8'd52},
	'{"T-95136-", "JE", "  ", 3'b101, 8'h00, 1'b1, 8'd30},
	'{"MK-1658 ", "8 ", "  ", 3'b001, 8'h00, 1'b0, 8'd120},
	'{"T-081156", "  ", "  ", 3'b000, 8'h00, 1'b0, 8'd126},
	'{"G-0000  ", "  ", "  ", 3'b000, 8'h00, 1'b0, 8'd44}
};

// words[i] goes to base + 2*i, code is flags, address, compare, replace
typedef struct packed {
	logic [24:0] base;
	logic [7:0][15:0] words;
	logic [127:0] code;
} code_vec_t;

localparam int n_code = 2;
localparam code_vec_t code_vecs [n_code] = '{
	'{25'h0000000,
		{16'h0000, 16'h9ABC, 16'h0000, 16'h5678, 16'h00FF, 16'h1234, 16'h0000, 16'h0001},
		128'h0000_0001_00FF_1234_0000_5678_0000_9ABC},
	'{25'h0000010,
		{16'h4444, 16'h3333, 16'h2222, 16'h1111, 16'h0003, 16'hBEEF, 16'h0102, 16'hA5A5},
		128'h0102_A5A5_0003_BEEF_2222_1111_4444_3333}
};

`endif

//--- bench/cart_load_tb.sv
//////////////////////////////////////////////////
// cartridge load front end testbench
// streams cart headers and cheat records through
// the DUT against a toggle-ack memory model
//////////////////////////////////////////////////
`timescale 1ns/100ps
`default_nettype none

module cart_load_tb;

	import cart_pkg::*;

	`include "cart_load_vectors.svh"

	// per word strobe, wait, ack and wait release, plus stream edges
	localparam int cycle_limit = (n_cart * 9 + n_code * 8) * (ack_delay_max + 4)
		+ (n_cart + n_code) * 6 + timeout_margin;

	logic clk_sys = 1'b0;
	logic rst;
	logic load_active;
	logic load_is_code;
	logic load_wr;
	load_addr_t load_addr;
	word_t load_wdata;
	logic load_wait;
	logic ram_req;
	logic ram_ack = 1'b0;
	logic [ram_addr_w-1:0] ram_addr;
	word_t ram_wdata;
	logic region_j;
	logic region_u;
	logic region_e;
	logic header_ready;
	quirk_t quirks;
	logic gun_type;
	logic [gun_delay_w-1:0] gun_delay;
	code_t code;
	logic code_valid;
	logic code_reset;

	logic ack_busy = 1'b0;
	int ack_cnt = 0;
	logic prev_req = 1'b0;
	int req_toggles = 0;
	int valid_pulses = 0;
	int reset_pulses = 0;
	int cycle_cnt = 0;
	int err_cnt = 0;
	int pass_cnt = 0;
	int test_cnt = 0;

	cart_load_top dut0 (.*);

	always #2 clk_sys = ~clk_sys;

	//////////////////////////////////////////////////
	// memory model echoes req onto ack 1 to 4 cycles after it sees the toggle
	//////////////////////////////////////////////////
	always @(posedge clk_sys) begin
		if (rst) begin
			ram_ack <= 1'b0;
			ack_busy <= 1'b0;
		end else if (ack_busy) begin
			if (ack_cnt == 0) begin
				ram_ack <= ram_req;
				ack_busy <= 1'b0;
			end else begin
				ack_cnt <= ack_cnt - 1;
			end
		end else if (ram_req != ram_ack) begin
			ack_busy <= 1'b1;
			ack_cnt <= $urandom_range(ack_delay_max - 1, 0);
		end
	end

	// pulse and toggle counters, plus the cycle limit
	always @(posedge clk_sys) begin
		if (ram_req !== prev_req)
			req_toggles++;
		prev_req = ram_req;
		if (code_valid === 1'b1)
			valid_pulses++;
		if (code_reset === 1'b1)
			reset_pulses++;
		cycle_cnt++;
		if (cycle_cnt > cycle_limit) begin
			$display("timeout: the run did not finish within %0d clock cycles",
				cycle_limit);
			$display("Test failures found");
			$finish;
		end
	end

	task automatic flag_error(input string msg);
		$display("FAIL @ %0t: %s", $time, msg);
		err_cnt++;
	endtask

	task automatic close_test(input string name, input int err_before);
		test_cnt++;
		if (err_cnt == err_before) begin
			pass_cnt++;
			$display("test %0d %s passed", test_cnt, name);
		end else begin
			$display("test %0d %s failed with %0d errors",
				test_cnt, name, err_cnt - err_before);
		end
	endtask

	// header id words carry the first char alone in the high byte and pairs low byte first
	function automatic word_t id_word(input logic [63:0] id, input int k);
		logic [7:0] c [8];
		for (int i = 0; i < 8; i++)
			c[i] = id[63 - 8 * i -: 8];
		if (k == 0)
			return {c[0], 8'h00};
		if (k == 4)
			return {8'h00, c[7]};
		return {c[2 * k], c[2 * k - 1]};
	endfunction

	//////////////////////////////////////////////////
	// one loader word and, for cart words, the rom write check
	//////////////////////////////////////////////////
	task automatic write_word(input load_addr_t addr, input word_t data);
		logic req_before;
		while (load_wait)
			@(negedge clk_sys);
		req_before = ram_req;
		load_addr = addr;
		load_wdata = data;
		load_wr = 1'b1;
		@(negedge clk_sys);
		load_wr = 1'b0;
		if (!load_is_code) begin
			if (ram_req === req_before)
				flag_error($sformatf("no ram_req toggle for addr %h", addr));
			if (ram_addr !== addr[24:1])
				flag_error($sformatf("ram_addr %h, expected %h", ram_addr, addr[24:1]));
			if (ram_wdata !== {data[7:0], data[15:8]})
				flag_error($sformatf("ram_wdata %h for load data %h", ram_wdata, data));
			if (load_wait !== 1'b1)
				flag_error($sformatf("load_wait low after write to %h", addr));
			while (load_wait)
				@(negedge clk_sys);
			if (ram_ack !== ram_req)
				flag_error("load_wait released before the ack matched the request");
		end
	endtask

	task automatic run_cart(input cart_vec_t v);
		int toggles_before;
		load_active = 1'b1;
		load_is_code = 1'b0;
		@(negedge clk_sys);
		// stream start wipes what the previous cart left behind
		if (quirks !== '0 || {region_j, region_u, region_e} !== 3'b000)
			flag_error("quirk or region flags not cleared at stream start");
		toggles_before = req_toggles;
		for (int k = 0; k < 5; k++)
			write_word(id_addr_first + load_addr_t'(2 * k), id_word(v.id, k));
		write_word(id_addr_decode, 16'h0000);
		if (quirks !== v.quirks)
			flag_error($sformatf("quirks %h, expected %h", quirks, v.quirks));
		if ({gun_type, gun_delay} !== {v.gun_type, v.gun_delay})
			flag_error($sformatf("gun %0d/%0d, expected %0d/%0d",
				gun_type, gun_delay, v.gun_type, v.gun_delay));
		write_word(hdr_region_lo, v.reg_lo);
		write_word(hdr_region_hi, v.reg_hi);
		write_word(hdr_end, 16'h0000);
		if ({region_j, region_u, region_e} !== v.region)
			flag_error($sformatf("region jue %b, expected %b",
				{region_j, region_u, region_e}, v.region));
		if (header_ready !== 1'b1)
			flag_error("header_ready low after the header end write");
		load_active = 1'b0;
		@(negedge clk_sys);
		if (header_ready !== 1'b0)
			flag_error("header_ready still high after the stream ended");
		@(negedge clk_sys);
		if (req_toggles - toggles_before != 9)
			flag_error($sformatf("%0d ram_req toggles for 9 words",
				req_toggles - toggles_before));
	endtask

	task automatic run_code(input code_vec_t v);
		int toggles_before;
		int valid_before;
		int reset_before;
		load_active = 1'b1;
		load_is_code = 1'b1;
		@(negedge clk_sys);
		toggles_before = req_toggles;
		valid_before = valid_pulses;
		reset_before = reset_pulses;
		for (int k = 0; k < 8; k++)
			write_word(v.base + load_addr_t'(2 * k), v.words[k]);
		// one cycle after the replace top word
		if (code_valid !== 1'b1)
			flag_error("code_valid low one cycle after the last code word");
		if (code !== v.code)
			flag_error($sformatf("code %h, expected %h", code, v.code));
		repeat (2) @(negedge clk_sys);
		if (valid_pulses - valid_before != 1)
			flag_error($sformatf("code_valid high %0d cycles", valid_pulses - valid_before));
		if (reset_pulses - reset_before != ((v.base == '0) ? 1 : 0))
			flag_error($sformatf("code_reset high %0d cycles", reset_pulses - reset_before));
		if (req_toggles != toggles_before)
			flag_error("code stream toggled ram_req");
		load_active = 1'b0;
		load_is_code = 1'b0;
		@(negedge clk_sys);
	endtask

	//////////////////////////////////////////////////
	// main sequence
	//////////////////////////////////////////////////
	initial begin
		int err_before;
		void'($urandom(32'hdf15_3383));
		rst = 1'b1;
		load_active = 1'b0;
		load_is_code = 1'b0;
		load_wr = 1'b0;
		load_addr = '0;
		load_wdata = '0;
		repeat (8) @(negedge clk_sys);
		rst = 1'b0;
		@(negedge clk_sys);
		err_before = err_cnt;
		if ({load_wait, ram_req, code_valid, code_reset, header_ready} !== 5'b00000)
			flag_error("a control output is not low after reset");
		if ({region_j, region_u, region_e} !== 3'b000 || quirks !== '0)
			flag_error("region or quirk flags set after reset");
		if (gun_delay !== 8'd44)
			flag_error($sformatf("gun_delay %0d after reset, expected 44", gun_delay));
		close_test("reset state", err_before);
		for (int k = 0; k < n_cart; k++) begin
			err_before = err_cnt;
			run_cart(cart_vecs[k]);
			close_test($sformatf("cart %s", cart_vecs[k].id), err_before);
		end
		for (int k = 0; k < n_code; k++) begin
			err_before = err_cnt;
			run_code(code_vecs[k]);
			close_test($sformatf("cheat record at %h", code_vecs[k].base), err_before);
		end
		$display("%0d tests, %0d passed, %0d failed, %0d errors",
			test_cnt, pass_cnt, test_cnt - pass_cnt, err_cnt);
		if (err_cnt == 0) begin
			$display("All tests passed!");
		end else begin
			$display("Test failures found");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- sim.f
hw/cart_pkg.sv
hw/rom_write_sync.sv
hw/header_region.sv
hw/cart_quirk_table.sv
hw/cheat_code_loader.sv
hw/cart_load_top.sv
+incdir+bench
bench/cart_load_tb.sv

//--- Makefile
# verilator build and run of the cartridge load testbench

LOG = sim.log

.PHONY: help test clean

help:
	@echo "make test   build the testbench with verilator, run it, check the log"
	@echo "make clean  remove the build folder and the log"
	@echo "make help   show this list"

test:
	verilator --binary --timing --top-module cart_load_tb -f sim.f -Mdir obj_dir -o cart_load_sim
	./obj_dir/cart_load_sim | tee $(LOG)
	@if grep -q "Test failures found" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "All tests passed!" $(LOG); then echo "simulation did not finish"; exit 1; fi
	@echo "simulation passed"

clean:
	rm -rf obj_dir $(LOG)
